// ==== rtl/byte_example_peri.sv ====
/* One read/write byte at offset 0, input pins readable at offset 1; others read 0 */
`timescale 1ns/10ps
`include "periph_cfg.svh"

module byte_example_peri import periph_pkg::*; (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     i_write,
    input  logic [3:0]               i_offset,
    input  logic [7:0]               i_data,
    input  logic [`PERIPH_PIN_W-1:0] i_ui_in,
    output logic [7:0]               o_rd_data,
    output logic [`PERIPH_PIN_W-1:0] o_uo_out
);

    localparam logic [3:0] REG_DATA = 4'h0;
    localparam logic [3:0] REG_PINS = 4'h1;

    logic [7:0] byte_reg;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            byte_reg <= '0;
        end else if (i_write && i_offset == REG_DATA) begin
            byte_reg <= i_data;
        end
    end

    always_comb begin
        case (i_offset)
            REG_DATA: o_rd_data = byte_reg;
            REG_PINS: o_rd_data = i_ui_in;
            default:  o_rd_data = 8'h00;
        endcase
    end

    assign o_uo_out = byte_reg;    // Pins mirror the register

endmodule

// ==== rtl/full_example_peri.sv ====
/* Writes at the data offset honour the access size; any write to the IRQ offset
   clears the flag. A new edge on input pin 0 in the same cycle wins. */
`timescale 1ns/10ps
`include "periph_cfg.svh"

module full_example_peri import periph_pkg::*; (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      i_sel,
    input  access_size_e              i_write_n,
    input  logic [5:0]                i_offset,
    input  logic [`PERIPH_DATA_W-1:0] i_data,
    input  logic [`PERIPH_PIN_W-1:0]  i_ui_in,
    output logic [`PERIPH_DATA_W-1:0] o_rd_data,
    output logic [`PERIPH_PIN_W-1:0]  o_uo_out,
    output logic                      o_interrupt
);

    logic [`PERIPH_DATA_W-1:0] data_reg;
    logic                      pin0_d;      // Last value of input pin 0
    logic                      wr_en;
    logic                      pin0_rise;

    assign wr_en     = i_sel && (i_write_n != ACC_NONE);
    assign pin0_rise = i_ui_in[0] && !pin0_d;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            data_reg    <= '0;
            pin0_d      <= 1'b0;
            o_interrupt <= 1'b0;
        end else begin
            pin0_d <= i_ui_in[0];
            if (wr_en && i_offset == `FULL_REG_DATA) begin
                case (i_write_n)
                    ACC_BYTE: data_reg[7:0]  <= i_data[7:0];
                    ACC_HALF: data_reg[15:0] <= i_data[15:0];
                    default:  data_reg       <= i_data;   // Word
                endcase
            end
            if (pin0_rise) begin
                o_interrupt <= 1'b1;
            end else if (wr_en && i_offset == `FULL_REG_IRQ) begin
                o_interrupt <= 1'b0;
            end
        end
    end

    always_comb begin
        case (i_offset)
            `FULL_REG_DATA: o_rd_data = data_reg;
            `FULL_REG_PINS: o_rd_data = {{(`PERIPH_DATA_W-`PERIPH_PIN_W){1'b0}}, i_ui_in};
            `FULL_REG_IRQ:  o_rd_data = {{(`PERIPH_DATA_W-1){1'b0}}, o_interrupt};
            default:        o_rd_data = '0;
        endcase
    end

    assign o_uo_out = data_reg[`PERIPH_PIN_W-1:0];

endmodule

// ==== rtl/gpio_ctrl.sv ====
/* Function select bit 4 picks the simple region, bits 3:0 the slot. Selecting the
   GPIO slot itself routes the output register; writes of any size take the low bits. */
`timescale 1ns/10ps
`include "periph_cfg.svh"

module gpio_ctrl import periph_pkg::*; (
    input  logic                                        clk,
    input  logic                                        rst_n,
    input  logic                                        i_sel,
    input  access_size_e                                i_write_n,
    input  logic [5:0]                                  i_offset,
    input  logic [`PERIPH_DATA_W-1:0]                   i_data,
    input  logic [`PERIPH_PIN_W-1:0]                    i_ui_in,
    input  logic [`PERIPH_SLOTS-1:0][`PERIPH_PIN_W-1:0] i_user_pins,
    input  logic [`PERIPH_SLOTS-1:0][`PERIPH_PIN_W-1:0] i_simple_pins,
    output logic [`PERIPH_DATA_W-1:0]                   o_rd_data,
    output logic [`PERIPH_PIN_W-1:0]                    o_uo_out
);

    localparam int FUNC_W = `PERIPH_FUNC_W;
    localparam logic [5:0] FUNC_BASE = `GPIO_REG_FUNC_BASE;
    localparam logic [FUNC_W-1:0] SEL_FULL = `PERIPH_SLOT_FULL_EX;
    localparam logic [FUNC_W-1:0] SEL_GPIO = `PERIPH_SLOT_GPIO;

    logic [`PERIPH_PIN_W-1:0]                    gpio_out;
    logic [FUNC_W-1:0]                           func_sel [`PERIPH_PIN_W];
    logic [`PERIPH_SLOTS-1:0][`PERIPH_PIN_W-1:0] user_pins;
    logic                                        wr_en;
    logic                                        func_hit;
    logic [2:0]                                  func_idx;

    assign wr_en    = i_sel && (i_write_n != ACC_NONE);
    assign func_hit = ((i_offset & 6'h23) == FUNC_BASE);  // 0x20 + 4 * pin
    assign func_idx = i_offset[4:2];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            gpio_out <= '0;
            for (int p = 0; p < `PERIPH_PIN_W; p++) begin
                func_sel[p] <= (p < 2) ? SEL_FULL : SEL_GPIO;
            end
        end else if (wr_en) begin
            if (i_offset == `GPIO_REG_OUT) gpio_out <= i_data[`PERIPH_PIN_W-1:0];
            if (func_hit) func_sel[func_idx] <= i_data[FUNC_W-1:0];
        end
    end

    always_comb begin
        o_rd_data = '0;
        if (i_offset == `GPIO_REG_OUT) begin
            o_rd_data[`PERIPH_PIN_W-1:0] = gpio_out;
        end else if (i_offset == `GPIO_REG_IN) begin
            o_rd_data[`PERIPH_PIN_W-1:0] = i_ui_in;
        end else if (func_hit) begin
            o_rd_data[FUNC_W-1:0] = func_sel[func_idx];
        end
    end

    // Own slot carries the output register
    always_comb begin
        user_pins = i_user_pins;
        user_pins[`PERIPH_SLOT_GPIO] = gpio_out;
    end

    // Each pin takes its own bit from the chosen slot
    for (genvar p = 0; p < `PERIPH_PIN_W; p++) begin : g_pin
        assign o_uo_out[p] = func_sel[p][FUNC_W-1] ? i_simple_pins[func_sel[p][3:0]][p]
                                                   : user_pins[func_sel[p][3:0]][p];
    end

endmodule

// ==== rtl/periph_addr_decode.sv ====
/* Combinational decode only. Simple slots always answer at once, and the unmapped
   region reads as zero with ready high. */
`timescale 1ns/10ps
`include "periph_cfg.svh"

module periph_addr_decode import periph_pkg::*; (
    input  logic [`PERIPH_ADDR_W-1:0]                    i_addr,
    input  access_size_e                                 i_write_n,
    input  logic [`PERIPH_SLOTS-1:0][`PERIPH_DATA_W-1:0] i_user_data,
    input  logic [`PERIPH_SLOTS-1:0]                     i_user_ready,
    input  logic [`PERIPH_SLOTS-1:0][7:0]                i_simple_data,
    output logic [`PERIPH_SLOTS-1:0]                     o_user_sel,
    output logic [`PERIPH_SLOTS-1:0]                     o_simple_wr,
    output logic [5:0]                                   o_offset,
    output logic [`PERIPH_DATA_W-1:0]                    o_peri_data,
    output logic                                         o_peri_ready
);

    addr_region_e              region;
    logic [3:0]                user_slot;
    logic [3:0]                simple_slot;
    logic [`PERIPH_SLOTS-1:0]  simple_sel;

    assign user_slot   = i_addr[9:6];
    assign simple_slot = i_addr[7:4];   // Bit 8 ignored, slots alias

    always_comb begin
        if (!i_addr[10]) begin
            region = REGION_USER;
        end else if (!i_addr[9]) begin
            region = REGION_SIMPLE;
        end else begin
            region = REGION_UNMAPPED;
        end
    end

    always_comb begin
        o_user_sel   = '0;
        simple_sel   = '0;
        o_peri_data  = '0;
        o_peri_ready = 1'b1;
        case (region)
            REGION_USER: begin
                o_user_sel[user_slot] = 1'b1;
                o_peri_data           = i_user_data[user_slot];
                o_peri_ready          = i_user_ready[user_slot];
            end
            REGION_SIMPLE: begin
                simple_sel[simple_slot] = 1'b1;
                o_peri_data             = {24'h0, i_simple_data[simple_slot]};
            end
            default: ;                  // Unmapped reads zero
        endcase
    end

    // Byte peripherals get a plain write strobe
    assign o_simple_wr = simple_sel & {`PERIPH_SLOTS{i_write_n != ACC_NONE}};

    assign o_offset = (region == REGION_SIMPLE) ? {2'b00, i_addr[3:0]} : i_addr[5:0];

endmodule

// ==== rtl/periph_cfg.svh ====
/* Bus widths, slot map and register offsets shared by the peripheral wrapper.
   Slot numbers must stay below PERIPH_SLOTS; offsets are 6-bit region-relative. */
`ifndef PERIPH_CFG_SVH
`define PERIPH_CFG_SVH

`define PERIPH_ADDR_W 11
`define PERIPH_DATA_W 32
`define PERIPH_PIN_W 8
`define PERIPH_SLOTS 16
`define PERIPH_FUNC_W 5

`define PERIPH_SLOT_GPIO 1
`define PERIPH_SLOT_FULL_EX 2
`define PERIPH_SIMPLE_BYTE_EX 0

`define GPIO_REG_OUT 6'h00
`define GPIO_REG_IN 6'h04
`define GPIO_REG_FUNC_BASE 6'h20

`define FULL_REG_DATA 6'h00
`define FULL_REG_PINS 6'h04
`define FULL_REG_IRQ 6'h08

`endif

// ==== rtl/periph_pkg.sv ====
/* Request codes follow the core encoding, where all ones means no access. */
package periph_pkg;

    // Size code on the read and write request lines
    typedef enum logic [1:0] {
        ACC_BYTE = 2'b00,
        ACC_HALF = 2'b01,
        ACC_WORD = 2'b10,
        ACC_NONE = 2'b11       // Idle
    } access_size_e;

    // Address region decoded from the top address bits
    typedef enum logic [1:0] {
        REGION_USER,           // 16 slots of 64 bytes
        REGION_SIMPLE,         // 16 byte slots of 16 bytes
        REGION_UNMAPPED
    } addr_region_e;

endpackage

// ==== rtl/periph_read_buffer.sv ====
/* Read data is captured once per read and held until the core pulses completion.
   Write acknowledge is combinational, so writes complete in the request cycle. */
`timescale 1ns/10ps
`include "periph_cfg.svh"

module periph_read_buffer import periph_pkg::*; (
    input  logic                      clk,
    input  logic                      rst_n,
    input  access_size_e              i_read_n,
    input  access_size_e              i_write_n,
    input  logic                      i_read_complete,
    input  logic [`PERIPH_DATA_W-1:0] i_peri_data,
    input  logic                      i_peri_ready,
    output logic [`PERIPH_DATA_W-1:0] o_data_out,
    output logic                      o_data_ready
);

    logic read_req;
    logic hold;        // Value captured, waiting for completion
    logic ready_r;
    logic capture;

    assign read_req = (i_read_n != ACC_NONE);
    assign capture  = read_req && i_peri_ready && !hold;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hold    <= 1'b0;
            ready_r <= 1'b0;
        end else begin
            if (i_read_complete) hold <= 1'b0;
            if (capture) hold <= 1'b1;           // Capture wins over completion
            ready_r <= read_req && i_peri_ready;
        end
    end

    always_ff @(posedge clk) begin
        if (capture) o_data_out <= i_peri_data;
    end

    assign o_data_ready = ready_r || (i_write_n != ACC_NONE);

endmodule

// ==== rtl/periph_top.sv ====
/* Only GPIO (user 1), the full example (user 2) and the byte example (simple 0) are
   populated. Every other slot reads zero with ready high and drives no pins. */
`timescale 1ns/10ps
`include "periph_cfg.svh"

module periph_top import periph_pkg::*; (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic [`PERIPH_ADDR_W-1:0] i_addr,
    input  logic [`PERIPH_DATA_W-1:0] i_data,
    input  access_size_e              i_write_n,
    input  access_size_e              i_read_n,
    input  logic                      i_read_complete,
    input  logic [`PERIPH_PIN_W-1:0]  i_ui_in,
    output logic [`PERIPH_DATA_W-1:0] o_data_out,
    output logic                      o_data_ready,
    output logic [`PERIPH_PIN_W-1:0]  o_uo_out,
    output logic                      o_interrupt
);

    logic [`PERIPH_SLOTS-1:0][`PERIPH_DATA_W-1:0] user_data;
    logic [`PERIPH_SLOTS-1:0]                     user_ready;
    logic [`PERIPH_SLOTS-1:0][`PERIPH_PIN_W-1:0]  user_pins;
    logic [`PERIPH_SLOTS-1:0][7:0]                simple_data;
    logic [`PERIPH_SLOTS-1:0][`PERIPH_PIN_W-1:0]  simple_pins;
    logic [`PERIPH_SLOTS-1:0]                     user_sel;
    logic [`PERIPH_SLOTS-1:0]                     simple_wr;
    logic [5:0]                                   offset;
    logic [`PERIPH_DATA_W-1:0]                    peri_data;
    logic                                         peri_ready;
    logic [`PERIPH_DATA_W-1:0]                    gpio_rd;
    logic [`PERIPH_DATA_W-1:0]                    full_rd;
    logic [`PERIPH_PIN_W-1:0]                     full_pins;
    logic [7:0]                                   byte_rd;
    logic [`PERIPH_PIN_W-1:0]                     byte_pins;

    // Slot arrays, empty slots answer zero at once
    always_comb begin
        user_data   = '0;
        user_ready  = '1;
        user_pins   = '0;               // GPIO slot pins filled in by gpio_ctrl
        simple_data = '0;
        simple_pins = '0;
        user_data[`PERIPH_SLOT_GPIO]        = gpio_rd;
        user_data[`PERIPH_SLOT_FULL_EX]     = full_rd;
        user_pins[`PERIPH_SLOT_FULL_EX]     = full_pins;
        simple_data[`PERIPH_SIMPLE_BYTE_EX] = byte_rd;
        simple_pins[`PERIPH_SIMPLE_BYTE_EX] = byte_pins;
    end

    periph_addr_decode u_decode (
        .i_addr(i_addr), .i_write_n(i_write_n),
        .i_user_data(user_data), .i_user_ready(user_ready), .i_simple_data(simple_data),
        .o_user_sel(user_sel), .o_simple_wr(simple_wr), .o_offset(offset),
        .o_peri_data(peri_data), .o_peri_ready(peri_ready)
    );

    periph_read_buffer u_read_buffer (
        .clk(clk), .rst_n(rst_n),
        .i_read_n(i_read_n), .i_write_n(i_write_n), .i_read_complete(i_read_complete),
        .i_peri_data(peri_data), .i_peri_ready(peri_ready),
        .o_data_out(o_data_out), .o_data_ready(o_data_ready)
    );

    gpio_ctrl u_gpio (
        .clk(clk), .rst_n(rst_n),
        .i_sel(user_sel[`PERIPH_SLOT_GPIO]), .i_write_n(i_write_n), .i_offset(offset),
        .i_data(i_data), .i_ui_in(i_ui_in),
        .i_user_pins(user_pins), .i_simple_pins(simple_pins),
        .o_rd_data(gpio_rd), .o_uo_out(o_uo_out)
    );

    full_example_peri u_full_ex (
        .clk(clk), .rst_n(rst_n),
        .i_sel(user_sel[`PERIPH_SLOT_FULL_EX]), .i_write_n(i_write_n), .i_offset(offset),
        .i_data(i_data), .i_ui_in(i_ui_in),
        .o_rd_data(full_rd), .o_uo_out(full_pins), .o_interrupt(o_interrupt)
    );

    byte_example_peri u_byte_ex (
        .clk(clk), .rst_n(rst_n),
        .i_write(simple_wr[`PERIPH_SIMPLE_BYTE_EX]), .i_offset(offset[3:0]),
        .i_data(i_data[7:0]), .i_ui_in(i_ui_in),
        .o_rd_data(byte_rd), .o_uo_out(byte_pins)
    );

endmodule

// ==== sources.f ====
+incdir+rtl
rtl/periph_pkg.sv
rtl/periph_addr_decode.sv
rtl/periph_read_buffer.sv
rtl/gpio_ctrl.sv
rtl/full_example_peri.sv
rtl/byte_example_peri.sv
rtl/periph_top.sv
tb/tb_clock_gen.sv
tb/periph_checker.sv
tb/periph_tb.sv

// ==== tb/periph_checker.sv ====
/* Bound into periph_top. A read counts as held from the cycle it is answered
   until the completion pulse. */
`timescale 1ns/10ps
`include "periph_cfg.svh"

module periph_checker import periph_pkg::*; (
    input logic                      clk,
    input logic                      rst_n,
    input access_size_e              i_write_n,
    input access_size_e              i_read_n,
    input logic                      i_data_ready,
    input logic                      i_read_complete,
    input logic [`PERIPH_DATA_W-1:0] i_data_out,
    input logic [`PERIPH_PIN_W-1:0]  i_ui_in,
    input logic                      i_interrupt
);

    int   assert_fails = 0;
    logic read_ack;     // Read request answered in this cycle
    logic held;         // Answered read not yet completed

    assign read_ack = (i_read_n != ACC_NONE) && (i_write_n == ACC_NONE) && i_data_ready;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            held <= 1'b0;
        end else if (i_read_complete) begin
            held <= 1'b0;
        end else if (read_ack) begin
            held <= 1'b1;
        end
    end

    // Writes are acknowledged in the request cycle
    a_write_ready: assert property (@(posedge clk) disable iff (!rst_n)
        (i_write_n != ACC_NONE) |-> i_data_ready)
        else begin
            assert_fails++;
            $error("Write request seen without ready");
        end

    a_hold_stable: assert property (@(posedge clk) disable iff (!rst_n)
        ((held || read_ack) && !i_read_complete) |=> $stable(i_data_out))
        else begin
            assert_fails++;
            $error("Held read data changed before completion");
        end

    // Flag follows the pin edge by one cycle
    a_irq_cause: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(i_interrupt) |-> $past($rose(i_ui_in[0])))
        else begin
            assert_fails++;
            $error("Interrupt rose without a rise on input pin 0");
        end

endmodule

// ==== tb/periph_tb.sv ====
/* Runs tb/periph_vectors.txt against periph_top; the simulator must start in the
   project root. Any wait gives up after WAIT_LIMIT cycles. */
`timescale 1ns/10ps
`include "periph_cfg.svh"

module periph_tb import periph_pkg::*; ();

    localparam int WAIT_LIMIT = 16;

    logic                      clk;
    logic                      rst_n;
    logic [`PERIPH_ADDR_W-1:0] addr;
    logic [`PERIPH_DATA_W-1:0] wdata;
    access_size_e              write_n;
    access_size_e              read_n;
    logic                      read_complete;
    logic [`PERIPH_PIN_W-1:0]  ui_in;
    logic [`PERIPH_DATA_W-1:0] data_out;
    logic                      data_ready;
    logic [`PERIPH_PIN_W-1:0]  uo_out;
    logic                      interrupt;
    logic [`PERIPH_ADDR_W-1:0] held_addr;     // Address of the read left open
    int errors = 0;
    int checks = 0;
    int test_errs = 0;
    int tests_run = 0;
    int cur_test = 0;

    tb_clock_gen u_clk_gen (.o_clk(clk), .o_rst_n(rst_n));

    periph_top uut (
        .clk(clk), .rst_n(rst_n), .i_addr(addr), .i_data(wdata),
        .i_write_n(write_n), .i_read_n(read_n), .i_read_complete(read_complete),
        .i_ui_in(ui_in), .o_data_out(data_out), .o_data_ready(data_ready),
        .o_uo_out(uo_out), .o_interrupt(interrupt)
    );

    bind periph_top periph_checker u_checker (
        .clk(clk), .rst_n(rst_n), .i_write_n(i_write_n), .i_read_n(i_read_n),
        .i_data_ready(o_data_ready), .i_read_complete(i_read_complete),
        .i_data_out(o_data_out), .i_ui_in(i_ui_in), .i_interrupt(o_interrupt)
    );

    function automatic string test_name(int id);
        case (id)
            1: return "sized_writes";
            2: return "gpio_output";
            3: return "func_select";
            4: return "interrupt";
            5: return "empty_slots";
            6: return "read_hold";
            default: return "unknown";
        endcase
    endfunction

    task automatic note_mismatch(string what, logic [31:0] exp, logic [31:0] act);
        $display("[FAIL] %s %s: expected %h, actual %h", test_name(cur_test), what, exp, act);
        errors++;
        test_errs++;
    endtask

    task automatic note_problem(string msg);
        $display("Error in %s: %s", test_name(cur_test), msg);
        errors++;
        test_errs++;
    endtask

    task automatic finish_test();
        if (cur_test != 0) begin
            tests_run++;
            $display("Test %0d %s: %0d errors", cur_test, test_name(cur_test), test_errs);
        end
        test_errs = 0;
    endtask

    task automatic pulse_complete();
        @(posedge clk);
        read_complete <= 1'b1;
        @(posedge clk);
        read_complete <= 1'b0;
    endtask

    task automatic do_write(logic [1:0] size, logic [10:0] a, logic [31:0] d);
        @(posedge clk);
        addr    <= a;
        wdata   <= d;
        write_n <= access_size_e'(size);
        @(negedge clk);
        checks++;
        if (data_ready !== 1'b1) note_problem("ready low during a write request");
        @(posedge clk);
        write_n <= ACC_NONE;
    endtask

    // Core holds the request until ready, then drops it one cycle later
    task automatic do_read(logic [1:0] size, logic [10:0] a, logic [31:0] exp, bit complete);
        int t;
        @(posedge clk);
        addr   <= a;
        read_n <= access_size_e'(size);
        t = 0;
        @(negedge clk);
        while (data_ready !== 1'b1 && t < WAIT_LIMIT) begin
            @(negedge clk);
            t++;
        end
        checks++;
        if (data_ready !== 1'b1) begin
            note_problem($sformatf("read of %h got no ready in %0d cycles", a, WAIT_LIMIT));
        end else begin
            if (t != 1) begin
                note_problem($sformatf("read of %h was ready after %0d cycles, not 1", a, t));
            end
            if (data_out !== exp) note_mismatch($sformatf("read %h", a), exp, data_out);
        end
        @(posedge clk);
        read_n <= ACC_NONE;
        if (complete) pulse_complete();
    endtask

    task automatic run_op(logic [3:0] op, logic [1:0] size, logic [10:0] a,
                          logic [31:0] d, logic [31:0] exp);
        case (op)
            4'h1: do_write(size, a, d);
            4'h2: do_read(size, a, exp, 1'b1);
            4'h3: begin
                @(posedge clk);
                ui_in <= d[`PERIPH_PIN_W-1:0];
            end
            4'h4: begin
                @(negedge clk);
                checks++;
                if (uo_out !== exp[`PERIPH_PIN_W-1:0]) begin
                    note_mismatch("o_uo_out", exp, {24'h0, uo_out});
                end
            end
            4'h5: begin
                @(posedge clk);             // Flag lags the pin edge by a cycle
                @(negedge clk);
                checks++;
                if (interrupt !== exp[0]) note_mismatch("o_interrupt", exp, {31'h0, interrupt});
            end
            4'h6: begin
                held_addr = a;
                do_read(size, a, exp, 1'b0);
            end
            4'h7: begin
                @(negedge clk);
                checks++;
                if (data_out !== exp) note_mismatch("held o_data_out", exp, data_out);
                // A new read while a value is held must return the held value
                do_read(ACC_WORD, held_addr, exp, 1'b1);
            end
            default: note_problem($sformatf("unknown operation code %h", op));
        endcase
    endtask

    initial begin
        string line;
        int fd;
        int n;
        int t;
        logic [31:0] f_test, f_op, f_size, f_addr, f_data, f_exp;
        addr          = '0;
        wdata         = '0;
        write_n       = ACC_NONE;
        read_n        = ACC_NONE;
        read_complete = 1'b0;
        ui_in         = '0;
        held_addr     = '0;
        void'($urandom(32'h9d79_f83d));
        t = 0;
        while (rst_n !== 1'b1 && t < WAIT_LIMIT) begin
            @(posedge clk);
            t++;
        end
        if (rst_n !== 1'b1) note_problem("reset was never released");
        fd = $fopen("tb/periph_vectors.txt", "r");
        if (fd == 0) begin
            note_problem("cannot open tb/periph_vectors.txt");
        end else begin
            while ($fgets(line, fd) > 0) begin
                if (line.len() < 2 || line[0] == "#") continue;
                n = $sscanf(line, "%h %h %h %h %h %h", f_test, f_op, f_size, f_addr,
                            f_data, f_exp);
                if (n != 6) begin
                    note_problem($sformatf("malformed vector line: %s", line));
                    continue;
                end
                if (f_test != cur_test) begin
                    finish_test();
                    cur_test = f_test;
                end
                repeat ($urandom % 4) @(posedge clk);   // Idle gap of 0 to 3 cycles
                run_op(f_op[3:0], f_size[1:0], f_addr[10:0], f_data, f_exp);
            end
            finish_test();
            $fclose(fd);
        end
        if (uut.u_checker.assert_fails != 0) begin
            $display("%0d bus protocol assertions failed", uut.u_checker.assert_fails);
            errors += uut.u_checker.assert_fails;
        end
        $display("Tests: %0d, checks: %0d, errors: %0d", tests_run, checks, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// ==== tb/periph_vectors.txt ====
# Columns (hex): test op size addr data expect
# Ops: 1 write, 2 read, 3 drive pins, 4 check pins, 5 check irq, 6 read and hold, 7 check held
# Test 1: word, byte and half-word writes to the full example
1 1 2 080 12345678 00000000
1 2 2 080 00000000 12345678
1 1 0 080 555555AB 00000000
1 2 2 080 00000000 123456AB
1 1 1 080 9999CDEF 00000000
1 2 2 080 00000000 1234CDEF
# Test 2: GPIO output register, reset routing and input readback
2 1 2 040 000000A4 00000000
2 2 2 040 00000000 000000A4
2 4 3 000 00000000 000000A7
2 3 3 000 0000005A 00000000
2 2 2 044 00000000 0000005A
# Test 3: pin 3 routed to simple slot 0
3 1 2 06C 00000010 00000000
3 2 2 06C 00000000 00000010
3 1 0 400 FFFFFF08 00000000
3 4 3 000 00000000 000000AF
3 1 0 400 000000F7 00000000
3 4 3 000 00000000 000000A7
3 2 0 400 00000000 000000F7
3 2 0 401 00000000 0000005A
# Test 4: interrupt on a rise of input pin 0, cleared by a write
4 5 3 000 00000000 00000000
4 3 3 000 0000005B 00000000
4 5 3 000 00000000 00000001
4 2 2 088 00000000 00000001
4 2 2 084 00000000 0000005B
4 1 2 088 00000000 00000000
4 2 2 088 00000000 00000000
4 5 3 000 00000000 00000000
# Test 5: empty user slot, empty simple slot and unmapped region
5 2 2 140 00000000 00000000
5 2 0 430 00000000 00000000
5 2 2 600 00000000 00000000
5 2 2 7F0 00000000 00000000
# Test 6: read data held across register writes until completion
6 6 2 080 00000000 1234CDEF
6 1 2 080 0BADF00D 00000000
6 1 0 080 00000011 00000000
6 7 3 000 00000000 1234CDEF
6 2 2 080 00000000 0BADF011

// ==== tb/tb_clock_gen.sv ====
/* Free-running 100 ns clock; reset held low for the first 3 rising edges */
`timescale 1ns/10ps

module tb_clock_gen (
    output logic o_clk,
    output logic o_rst_n
);

    initial begin
        o_clk = 1'b0;
        forever #50 o_clk = ~o_clk;     // Half period
    end

    initial begin
        o_rst_n = 1'b0;
        repeat (3) @(posedge o_clk);
        o_rst_n <= 1'b1;
    end

endmodule
